// File: Makefile
# Verilator flow for the bucket integrity verifier

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --top-module integrityVerifierTb -f sources.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module integrityVerifierTb \
		-f sources.f -o integrityVerifierSim
	./obj_dir/integrityVerifierSim | tee $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/clockGen.sv
/*
 * Testbench clock and reset.
 * Period of 8, reset held high for the first 10 cycles.
 */
`default_nettype none

module clockGen (
	output logic Clock,
	output logic reset
);

	initial begin
		Clock = 1'b0;
		forever begin
			#4 Clock = ~Clock;
		end
	end

	// synchronous reset released away from the rising edge
	initial begin
		reset = 1'b1;
		repeat (10) @(posedge Clock);
		@(negedge Clock);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: sim/integrityVerifierTb.sv
/*
 * Integrity verifier testbench. Random buckets in a memory model,
 * back-to-back commands with random memory and verdict latency,
 * verdicts checked in order against a reference hash model.
 */
`default_nettype none

module integrityVerifierTb import integrityPkg::*; ();

	localparam int NUM_ENGINES = 3;
	localparam int BUCKET_WORDS = 8;
	localparam int HASH_ROUNDS = 4;
	localparam int NUM_BUCKETS = 64;
	localparam int MEM_WORDS = NUM_BUCKETS * (BUCKET_WORDS + 1);
	localparam int TIMEOUT_CYCLES = NUM_BUCKETS * (BUCKET_WORDS + 1) * 10 + 2000;

	logic Clock;
	logic reset;
	logic cmdReq;
	bucketId_t cmdBucketId;
	logic cmdAck;
	logic memReq;
	memAddr_t memAddr;
	logic memAck;
	word_t memData;
	logic verdictReq;
	verdict_t verdict;
	logic verdictAck;

	logic [31:0] lfsrState = 32'h3099359e;
	int errorCount = 0;
	int checkCount = 0;
	int verdictCount = 0;
	int cycleCount = 0;
	word_t memory [MEM_WORDS];
	logic expectedOk [NUM_BUCKETS];
	bucketId_t commandOrder [NUM_BUCKETS];
	verdict_t expectedVerdicts [$];

	clockGen i_clockGen (
		.Clock(Clock),
		.reset(reset)
	);

	integrityVerifier #(
		.NUM_ENGINES(NUM_ENGINES),
		.BUCKET_WORDS(BUCKET_WORDS),
		.HASH_ROUNDS(HASH_ROUNDS)
	) i_integrityVerifier (
		.Clock(Clock),
		.reset(reset),
		.cmdReq(cmdReq),
		.cmdBucketId(cmdBucketId),
		.cmdAck(cmdAck),
		.memReq(memReq),
		.memAddr(memAddr),
		.memAck(memAck),
		.memData(memData),
		.verdictReq(verdictReq),
		.verdict(verdict),
		.verdictAck(verdictAck)
	);

	// ========================================
	// random numbers and reference model
	// ========================================
	// fibonacci lfsr with taps 32 22 2 1 and one step per bit
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	function automatic word_t rotateLeft(input word_t value, input int amount);
		word_t rotated;
		rotated = value;
		for (int i = 0; i < amount; i++) begin
			rotated = {rotated[30:0], rotated[31]};
		end
		return rotated;
	endfunction

	// digest of the data words currently in memory for one bucket
	function automatic word_t modelDigest(input bucketId_t id);
		word_t state;
		int base;
		base = int'(id) * (BUCKET_WORDS + 1);
		state = SEED_MASK ^ {16'h0000, id};
		for (int w = 0; w < BUCKET_WORDS; w++) begin
			state = state ^ memory[base + 1 + w];
			for (int r = 0; r < HASH_ROUNDS; r++) begin
				state = rotateLeft(state, ROTATE_AMOUNT) + ROUND_CONSTANT;
			end
		end
		return state;
	endfunction

	task automatic checkValue(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Mismatch at time %0t: %s is %0h, expected %0h",
				$time, what, actual, expected);
		end
	endtask

	// random data, then a good tag, a corrupted tag or a flipped data bit
	task automatic buildMemory();
		int base;
		int flipIndex;
		logic [1:0] kind;
		word_t good;
		for (int b = 0; b < NUM_BUCKETS; b++) begin
			base = b * (BUCKET_WORDS + 1);
			for (int w = 0; w < BUCKET_WORDS; w++) begin
				memory[base + 1 + w] = randomBits(32);
			end
			good = modelDigest(bucketId_t'(b));
			kind = 2'(randomBits(2));
			case (kind)
				2'd2: begin
					memory[base] = good ^ (randomBits(32) | 32'h1);
					expectedOk[b] = 1'b0;
				end
				2'd3: begin
					// tag was right until one data bit flipped
					memory[base] = good;
					flipIndex = int'(randomBits(3)) % BUCKET_WORDS;
					memory[base + 1 + flipIndex] ^= 32'h1 << randomBits(5);
					expectedOk[b] = 1'b0;
				end
				default: begin
					memory[base] = good;
					expectedOk[b] = 1'b1;
				end
			endcase
		end
	endtask

	task automatic issueCommand(input bucketId_t id);
		verdict_t expected;
		expected.bucketId = id;
		expected.ok = expectedOk[id];
		expectedVerdicts.push_back(expected);
		cmdBucketId = id;
		cmdReq = 1'b1;
		do @(negedge Clock); while (!cmdAck);
		cmdReq = 1'b0;
		do @(negedge Clock); while (cmdAck);
	endtask

	task automatic reportAndFinish();
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial begin : mainSequence
		bucketId_t swap;
		int pick;
		cmdReq = 1'b0;
		cmdBucketId = '0;
		buildMemory();
		// every bucket once in shuffled order
		for (int i = 0; i < NUM_BUCKETS; i++) begin
			commandOrder[i] = bucketId_t'(i);
		end
		for (int i = NUM_BUCKETS - 1; i > 0; i--) begin
			pick = int'(randomBits(6)) % (i + 1);
			swap = commandOrder[i];
			commandOrder[i] = commandOrder[pick];
			commandOrder[pick] = swap;
		end
		do @(negedge Clock); while (reset);
		// quiet outputs with no command
		repeat (20) begin
			@(negedge Clock);
			checkValue("cmdAck while idle", 32'(cmdAck), 32'h0);
			checkValue("memReq while idle", 32'(memReq), 32'h0);
			checkValue("verdictReq while idle", 32'(verdictReq), 32'h0);
		end
		for (int i = 0; i < NUM_BUCKETS; i++) begin
			issueCommand(commandOrder[i]);
		end
		do @(negedge Clock); while (verdictCount < NUM_BUCKETS);
		// room for a stray extra verdict to show up
		repeat (50) @(negedge Clock);
		checkValue("verdict count", 32'(verdictCount), 32'(NUM_BUCKETS));
		checkValue("verdicts still expected", 32'(expectedVerdicts.size()), 32'h0);
		reportAndFinish();
	end

	// memory answers after 0 to 7 cycles
	initial begin : memoryModel
		int delay;
		int readIndex;
		int expectedAddr;
		memAck = 1'b0;
		memData = '0;
		readIndex = 0;
		forever begin
			@(negedge Clock);
			if (memReq && !memAck) begin
				// tag and then data words of each bucket, in command order
				if (readIndex < MEM_WORDS) begin
					expectedAddr = int'(commandOrder[readIndex / (BUCKET_WORDS + 1)])
						* (BUCKET_WORDS + 1) + readIndex % (BUCKET_WORDS + 1);
					checkValue("memory read address", 32'(memAddr), 32'(expectedAddr));
				end else begin
					errorCount++;
					$display("More memory reads than the commands need at time %0t",
						$time);
				end
				readIndex++;
				delay = int'(randomBits(3));
				repeat (delay) @(negedge Clock);
				if (int'(memAddr) < MEM_WORDS) begin
					memData = memory[memAddr];
				end else begin
					errorCount++;
					$display("Memory read outside the model at address %0h, time %0t",
						memAddr, $time);
					memData = '0;
				end
				memAck = 1'b1;
				do @(negedge Clock); while (memReq);
				memAck = 1'b0;
			end
		end
	end

	// verdict receiver with up to 20 cycles of ack delay
	initial begin : verdictSink
		int delay;
		verdict_t expected;
		verdictAck = 1'b0;
		forever begin
			@(negedge Clock);
			if (verdictReq && !verdictAck) begin
				if (expectedVerdicts.size() == 0) begin
					errorCount++;
					$display("Unexpected verdict for bucket %0d at time %0t, none outstanding",
						verdict.bucketId, $time);
				end else begin
					expected = expectedVerdicts.pop_front();
					checkValue("verdict bucket ID", 32'(verdict.bucketId),
						32'(expected.bucketId));
					checkValue($sformatf("verdict ok for bucket %0d", expected.bucketId),
						32'(verdict.ok), 32'(expected.ok));
				end
				verdictCount++;
				delay = int'(randomBits(5)) % 21;
				repeat (delay) @(negedge Clock);
				verdictAck = 1'b1;
				do @(negedge Clock); while (verdictReq);
				verdictAck = 1'b0;
			end
		end
	end

	initial begin : watchdog
		while (cycleCount < TIMEOUT_CYCLES) begin
			@(posedge Clock);
			cycleCount++;
		end
		errorCount++;
		$display("Timeout: run not finished after %0d cycles, %0d of %0d verdicts seen",
			TIMEOUT_CYCLES, verdictCount, NUM_BUCKETS);
		reportAndFinish();
	end

endmodule

`default_nettype wire

// File: sim/integrityVerifier_checker.sv
/*
 * Four-phase handshake assertions on the command, memory and
 * verdict interfaces of the integrity verifier.
 */
`default_nettype none

module integrityVerifierChecker import integrityPkg::*; (
	input wire logic Clock,
	input wire logic reset,
	input wire logic cmdReq,
	input wire bucketId_t cmdBucketId,
	input wire logic cmdAck,
	input wire logic memReq,
	input wire memAddr_t memAddr,
	input wire logic memAck,
	input wire word_t memData,
	input wire logic verdictReq,
	input wire verdict_t verdict,
	input wire logic verdictAck
);

	// ========================================
	// command interface
	// ========================================
	cmdReqHold: assert property (@(posedge Clock) disable iff (reset)
		$fell(cmdReq) |-> cmdAck || $past(cmdAck))
		else $error("cmdReq dropped before cmdAck was raised");
	cmdAckHold: assert property (@(posedge Clock) disable iff (reset)
		$fell(cmdAck) |-> !cmdReq || !$past(cmdReq))
		else $error("cmdAck dropped while cmdReq was still high");
	cmdIdStable: assert property (@(posedge Clock) disable iff (reset)
		cmdReq && $past(cmdReq) |-> $stable(cmdBucketId))
		else $error("cmdBucketId changed while cmdReq was high");

	// ========================================
	// memory interface
	// ========================================
	memReqHold: assert property (@(posedge Clock) disable iff (reset)
		$fell(memReq) |-> memAck || $past(memAck))
		else $error("memReq dropped before memAck was raised");
	memAckHold: assert property (@(posedge Clock) disable iff (reset)
		$fell(memAck) |-> !memReq || !$past(memReq))
		else $error("memAck dropped while memReq was still high");
	memAddrStable: assert property (@(posedge Clock) disable iff (reset)
		memReq && $past(memReq) |-> $stable(memAddr))
		else $error("memAddr changed while memReq was high");
	memDataStable: assert property (@(posedge Clock) disable iff (reset)
		memAck && $past(memAck) |-> $stable(memData))
		else $error("memData changed while memAck was high");

	// ========================================
	// verdict interface
	// ========================================
	verdictReqHold: assert property (@(posedge Clock) disable iff (reset)
		$fell(verdictReq) |-> verdictAck || $past(verdictAck))
		else $error("verdictReq dropped before verdictAck was raised");
	verdictAckHold: assert property (@(posedge Clock) disable iff (reset)
		$fell(verdictAck) |-> !verdictReq || !$past(verdictReq))
		else $error("verdictAck dropped while verdictReq was still high");
	verdictStable: assert property (@(posedge Clock) disable iff (reset)
		verdictReq && $past(verdictReq) |-> $stable(verdict))
		else $error("verdict payload changed while verdictReq was high");

endmodule

bind integrityVerifier integrityVerifierChecker i_integrityVerifierChecker (
	.Clock(Clock),
	.reset(reset),
	.cmdReq(cmdReq),
	.cmdBucketId(cmdBucketId),
	.cmdAck(cmdAck),
	.memReq(memReq),
	.memAddr(memAddr),
	.memAck(memAck),
	.memData(memData),
	.verdictReq(verdictReq),
	.verdict(verdict),
	.verdictAck(verdictAck)
);

`default_nettype wire

// File: source/bucketFetch.sv
/*
 * Bucket fetcher. Takes a bucket ID over the command handshake,
 * reads the tag word and the data words from memory, and offers
 * each data word as a beat to the hash pool.
 */
`default_nettype none

module bucketFetch import integrityPkg::*; #(
	parameter int BUCKET_WORDS = 8
) (
	input wire logic Clock,
	input wire logic reset,
	// command handshake
	input wire logic cmdReq,
	input wire bucketId_t cmdBucketId,
	output logic cmdAck,
	// memory read handshake
	output logic memReq,
	output memAddr_t memAddr,
	input wire logic memAck,
	input wire word_t memData,
	// beat stream to the pool
	output hashBeat_t beat,
	output logic beatValid,
	input wire logic beatReady
);

	localparam int COUNT_WIDTH = (BUCKET_WORDS > 1) ? $clog2(BUCKET_WORDS) : 1;
	localparam logic [COUNT_WIDTH-1:0] LAST_WORD = COUNT_WIDTH'(BUCKET_WORDS - 1);

	typedef enum logic [2:0] {
		idle,
		readTag,
		readWord,
		offerBeat,
		waitCmdDrop
	} fetchState_t;

	fetchState_t state;
	logic gotData;
	logic [COUNT_WIDTH-1:0] wordCount;
	bucketId_t bucketIdReg;
	word_t tagReg;
	word_t dataReg;

	// ========================================
	// control
	// ========================================
	always_ff @(posedge Clock) begin
		if (reset) begin
			state <= idle;
			cmdAck <= 1'b0;
			memReq <= 1'b0;
			gotData <= 1'b0;
			wordCount <= '0;
		end else begin
			// ack falls once the client lets go, whatever the fetch is doing
			if (cmdAck && !cmdReq) begin
				cmdAck <= 1'b0;
			end
			case (state)
				idle: begin
					if (cmdReq && !cmdAck) begin
						cmdAck <= 1'b1;
						wordCount <= '0;
						gotData <= 1'b0;
						state <= readTag;
					end
				end
				readTag, readWord: begin
					// full four-phase cycle per word
					if (memReq) begin
						if (memAck) begin
							memReq <= 1'b0;
							gotData <= 1'b1;
						end
					end else if (gotData) begin
						if (!memAck) begin
							gotData <= 1'b0;
							state <= (state == readTag) ? readWord : offerBeat;
						end
					end else begin
						memReq <= 1'b1;
					end
				end
				offerBeat: begin
					if (beatReady) begin
						if (wordCount == LAST_WORD) begin
							state <= waitCmdDrop;
						end else begin
							wordCount <= wordCount + 1'b1;
							state <= readWord;
						end
					end
				end
				waitCmdDrop: begin
					if (!cmdAck) begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// ========================================
	// address and captured words
	// ========================================
	always_ff @(posedge Clock) begin
		if (state == idle && cmdReq && !cmdAck) begin
			bucketIdReg <= cmdBucketId;
			// tag first, data words right behind it
			memAddr <= memAddr_t'(cmdBucketId) * memAddr_t'(BUCKET_WORDS + 1);
		end else if (memReq && memAck) begin
			if (state == readTag) begin
				tagReg <= memData;
			end else begin
				dataReg <= memData;
			end
			memAddr <= memAddr + 1'b1;
		end
	end

	assign beatValid = (state == offerBeat);
	assign beat.word = dataReg;
	assign beat.bucketId = bucketIdReg;
	assign beat.tag = tagReg;
	assign beat.first = (wordCount == '0);
	assign beat.last = (wordCount == LAST_WORD);

endmodule

`default_nettype wire

// File: source/bucketHashEngine.sv
/*
 * Bucket hash engine. Seeds from the bucket ID, folds in each
 * data word by XOR and runs HASH_ROUNDS mixing rounds per word,
 * then holds the digest with the stored tag until it is taken.
 */
`default_nettype none

module bucketHashEngine import integrityPkg::*; #(
	parameter int HASH_ROUNDS = 4
) (
	input wire logic Clock,
	input wire logic reset,
	input wire hashBeat_t beat,
	input wire logic beatValid,
	output logic beatReady,
	output hashResult_t result,
	output logic resultValid,
	input wire logic resultReady
);

	localparam int ROUND_WIDTH = (HASH_ROUNDS > 1) ? $clog2(HASH_ROUNDS) : 1;
	localparam logic [ROUND_WIDTH-1:0] LAST_ROUND = ROUND_WIDTH'(HASH_ROUNDS - 1);

	typedef enum logic [1:0] {
		idle,
		mixing,
		waitWord,
		done
	} engineState_t;

	engineState_t state;
	logic [ROUND_WIDTH-1:0] roundCount;
	logic lastWord;
	logic beatTaken;
	word_t hashState;
	bucketId_t bucketIdReg;
	digest_t tagReg;

	assign beatReady = (state == idle) || (state == waitWord);
	assign beatTaken = beatValid && beatReady;

	// ========================================
	// control
	// ========================================
	always_ff @(posedge Clock) begin
		if (reset) begin
			state <= idle;
			roundCount <= '0;
			lastWord <= 1'b0;
		end else begin
			case (state)
				idle, waitWord: begin
					if (beatTaken) begin
						roundCount <= '0;
						lastWord <= beat.last;
						state <= mixing;
					end
				end
				mixing: begin
					if (roundCount == LAST_ROUND) begin
						state <= lastWord ? done : waitWord;
					end else begin
						roundCount <= roundCount + 1'b1;
					end
				end
				done: begin
					if (resultReady) begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// ========================================
	// hash datapath
	// ========================================
	always_ff @(posedge Clock) begin
		if (beatTaken) begin
			// first word restarts from the seed
			hashState <= (beat.first ? hashSeed(beat.bucketId) : hashState) ^ beat.word;
			if (beat.first) begin
				bucketIdReg <= beat.bucketId;
				tagReg <= beat.tag;
			end
		end else if (state == mixing) begin
			hashState <= hashRound(hashState);
		end
	end

	assign resultValid = (state == done);
	assign result.bucketId = bucketIdReg;
	assign result.digest = hashState;
	assign result.tag = tagReg;

endmodule

`default_nettype wire

// File: source/digestCompare.sv
/*
 * Digest compare. Takes one result at a time, checks the digest
 * against the stored tag and reports the verdict over four-phase.
 */
`default_nettype none

module digestCompare import integrityPkg::*; (
	input wire logic Clock,
	input wire logic reset,
	input wire hashResult_t result,
	input wire logic resultValid,
	output logic resultReady,
	output verdict_t verdict,
	output logic verdictReq,
	input wire logic verdictAck
);

	logic resultTaken;

	// only take a result while the verdict handshake is fully idle
	assign resultReady = !verdictReq && !verdictAck;
	assign resultTaken = resultValid && resultReady;

	always_ff @(posedge Clock) begin
		if (reset) begin
			verdictReq <= 1'b0;
		end else begin
			if (resultTaken) begin
				verdictReq <= 1'b1;
			end else if (verdictReq && verdictAck) begin
				verdictReq <= 1'b0;
			end
		end
	end

	// verdict payload held while the request is up
	always_ff @(posedge Clock) begin
		if (resultTaken) begin
			verdict.bucketId <= result.bucketId;
			verdict.ok <= (result.digest == result.tag);
		end
	end

endmodule

`default_nettype wire

// File: source/hashPool.sv
/*
 * Hash engine pool. Hands whole buckets to the engines in turn
 * and collects digests in the same turn order, so results leave
 * in request order.
 */
`default_nettype none

module hashPool import integrityPkg::*; #(
	parameter int NUM_ENGINES = 3,
	parameter int HASH_ROUNDS = 4
) (
	input wire logic Clock,
	input wire logic reset,
	input wire hashBeat_t beat,
	input wire logic beatValid,
	output logic beatReady,
	output hashResult_t result,
	output logic resultValid,
	input wire logic resultReady
);

	localparam int TURN_WIDTH = (NUM_ENGINES > 1) ? $clog2(NUM_ENGINES) : 1;

	logic [TURN_WIDTH-1:0] inTurn;
	logic [TURN_WIDTH-1:0] outTurn;
	logic [NUM_ENGINES-1:0] engineBeatValid;
	logic [NUM_ENGINES-1:0] engineBeatReady;
	logic [NUM_ENGINES-1:0] engineResultValid;
	logic [NUM_ENGINES-1:0] engineResultReady;
	hashResult_t engineResult [NUM_ENGINES];

	function automatic logic [TURN_WIDTH-1:0] nextTurn(input logic [TURN_WIDTH-1:0] turn);
		if (turn == TURN_WIDTH'(NUM_ENGINES - 1)) begin
			return '0;
		end
		return turn + 1'b1;
	endfunction

	// ========================================
	// turn pointers
	// ========================================
	always_ff @(posedge Clock) begin
		if (reset) begin
			inTurn <= '0;
			outTurn <= '0;
		end else begin
			// a bucket is handed over completely before the next engine gets one
			if (beatValid && beatReady && beat.last) begin
				inTurn <= nextTurn(inTurn);
			end
			if (resultValid && resultReady) begin
				outTurn <= nextTurn(outTurn);
			end
		end
	end

	assign beatReady = engineBeatReady[inTurn];
	assign result = engineResult[outTurn];
	assign resultValid = engineResultValid[outTurn];

	genvar k;
	generate
		for (k = 0; k < NUM_ENGINES; k++) begin : engines
			assign engineBeatValid[k] = beatValid && (inTurn == TURN_WIDTH'(k));
			assign engineResultReady[k] = resultReady && (outTurn == TURN_WIDTH'(k));

			bucketHashEngine #(
				.HASH_ROUNDS(HASH_ROUNDS)
			) i_bucketHashEngine (
				.Clock(Clock),
				.reset(reset),
				.beat(beat),
				.beatValid(engineBeatValid[k]),
				.beatReady(engineBeatReady[k]),
				.result(engineResult[k]),
				.resultValid(engineResultValid[k]),
				.resultReady(engineResultReady[k])
			);
		end
	endgenerate

endmodule

`default_nettype wire

// File: source/integrityPkg.sv
/*
 * Integrity verifier shared definitions.
 * Word, bucket ID, digest and address types, the stream structs
 * between blocks, and the keyed mixing hash used per bucket.
 */
`default_nettype none

package integrityPkg;

	// ========================================
	// widths and vector types
	// ========================================
	localparam int WORD_WIDTH = 32;
	localparam int BUCKET_ID_WIDTH = 16;
	localparam int MEM_ADDR_WIDTH = 20;

	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [BUCKET_ID_WIDTH-1:0] bucketId_t;
	// tag sits in a single memory word, so the digest is one word wide
	typedef logic [WORD_WIDTH-1:0] digest_t;
	typedef logic [MEM_ADDR_WIDTH-1:0] memAddr_t;

	// ========================================
	// hash constants
	// ========================================
	localparam word_t ROUND_CONSTANT = 32'h9e3779b9;
	localparam int ROTATE_AMOUNT = 7;
	localparam word_t SEED_MASK = 32'ha5a5a5a5;

	// one fetched data word on its way into the pool
	typedef struct packed {
		word_t word;
		bucketId_t bucketId;
		digest_t tag;
		logic first;
		logic last;
	} hashBeat_t;

	typedef struct packed {
		bucketId_t bucketId;
		digest_t digest;
		digest_t tag;
	} hashResult_t;

	typedef struct packed {
		bucketId_t bucketId;
		logic ok;
	} verdict_t;

	// start state for a bucket
	function automatic word_t hashSeed(input bucketId_t id);
		return SEED_MASK ^ word_t'(id);
	endfunction

	// one mixing round rotates left and then adds the round constant
	function automatic word_t hashRound(input word_t state);
		word_t rotated;
		rotated = (state << ROTATE_AMOUNT) | (state >> (WORD_WIDTH - ROTATE_AMOUNT));
		return rotated + ROUND_CONSTANT;
	endfunction

endpackage

`default_nettype wire

// File: source/integrityVerifier.sv
/*
 * Bucket integrity verifier top level.
 * Fetcher, hash pool and digest compare in a row.
 */
`default_nettype none

module integrityVerifier import integrityPkg::*; #(
	parameter int NUM_ENGINES = 3,
	parameter int BUCKET_WORDS = 8,
	parameter int HASH_ROUNDS = 4
) (
	input wire logic Clock,
	input wire logic reset,
	// command
	input wire logic cmdReq,
	input wire bucketId_t cmdBucketId,
	output logic cmdAck,
	// memory
	output logic memReq,
	output memAddr_t memAddr,
	input wire logic memAck,
	input wire word_t memData,
	// verdict
	output logic verdictReq,
	output verdict_t verdict,
	input wire logic verdictAck
);

	hashBeat_t beat;
	logic beatValid;
	logic beatReady;
	hashResult_t result;
	logic resultValid;
	logic resultReady;

	bucketFetch #(
		.BUCKET_WORDS(BUCKET_WORDS)
	) i_bucketFetch (
		.Clock(Clock),
		.reset(reset),
		.cmdReq(cmdReq),
		.cmdBucketId(cmdBucketId),
		.cmdAck(cmdAck),
		.memReq(memReq),
		.memAddr(memAddr),
		.memAck(memAck),
		.memData(memData),
		.beat(beat),
		.beatValid(beatValid),
		.beatReady(beatReady)
	);

	hashPool #(
		.NUM_ENGINES(NUM_ENGINES),
		.HASH_ROUNDS(HASH_ROUNDS)
	) i_hashPool (
		.Clock(Clock),
		.reset(reset),
		.beat(beat),
		.beatValid(beatValid),
		.beatReady(beatReady),
		.result(result),
		.resultValid(resultValid),
		.resultReady(resultReady)
	);

	digestCompare i_digestCompare (
		.Clock(Clock),
		.reset(reset),
		.result(result),
		.resultValid(resultValid),
		.resultReady(resultReady),
		.verdict(verdict),
		.verdictReq(verdictReq),
		.verdictAck(verdictAck)
	);

endmodule

`default_nettype wire

// File: sources.f
source/integrityPkg.sv
source/bucketFetch.sv
source/bucketHashEngine.sv
source/hashPool.sv
source/digestCompare.sv
source/integrityVerifier.sv
sim/clockGen.sv
sim/integrityVerifier_checker.sv
sim/integrityVerifierTb.sv
